//--- Makefile
SIM  := obj_dir/Vtb_dot11_tx_coder
SRCS := $(shell cat dot11_tx_coder.f)

.PHONY: all run clean

all: run

$(SIM): dot11_tx_coder.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_dot11_tx_coder \
		--Mdir obj_dir -f dot11_tx_coder.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir

//--- design/bit_serializer.sv
`timescale 1ns/1ps

module bit_serializer (
    input  logic                     clk,
    input  logic                     reset_int,
    input  dot11_tx_pkg::frame_hdr_t i_hdr,
    input  logic                     i_hdr_valid,
    output logic                     o_hdr_ready,
    input  dot11_tx_pkg::byte_beat_t i_byte,
    input  logic                     i_byte_valid,
    output logic                     o_byte_ready,
    output dot11_tx_pkg::tx_bit_t    o_bit,
    output logic                     o_bit_valid,
    input  logic                     i_bit_ready
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_SERVICE,
        S_BYTE,
        S_TAIL,
        S_PAD
    } state_e;

    state_e                state;
    dot11_tx_pkg::rate_e   rate_q;
    dot11_tx_pkg::tx_bit_t nxt_bit;
    logic [7:0]            dbps;
    logic [7:0]            sym_cnt;
    logic [3:0]            svc_cnt;
    logic [2:0]            bit_idx;
    logic [2:0]            tail_cnt;
    logic                  out_free;
    logic                  emit;
    logic                  sym_wrap;
    logic                  tail_done;

    assign out_free  = !o_bit_valid || i_bit_ready;
    assign dbps      = dot11_tx_pkg::dbps_for_rate(rate_q);
    assign sym_wrap  = (sym_cnt == dbps - 8'd1);
    assign tail_done = (tail_cnt == 3'(dot11_tx_pkg::TAIL_BITS - 1));

    // Header is paired with the first byte, which stays put until its
    // eighth bit goes out
    assign o_hdr_ready  = (state == S_IDLE) && out_free && i_byte_valid && i_byte.first;
    assign o_byte_ready = (state == S_BYTE) && out_free && (bit_idx == 3'd7);

    //////////////////////////////////////////////////////////////////////
    // Next bit
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        emit          = 1'b0;
        nxt_bit       = '0;
        nxt_bit.field = dot11_tx_pkg::FIELD_SERVICE;
        case (state)
            S_IDLE: begin
                // First SERVICE bit leaves with the header
                emit               = i_hdr_valid && o_hdr_ready;
                nxt_bit.first      = 1'b1;
                nxt_bit.scram_seed = i_hdr.scram_seed;
            end
            S_SERVICE: begin
                emit = out_free;
            end
            S_BYTE: begin
                emit             = out_free && i_byte_valid;
                nxt_bit.data_bit = i_byte.data[bit_idx];
                // Only the closing FCS byte is marked on the byte stream
                nxt_bit.field    = i_byte.last ? dot11_tx_pkg::FIELD_FCS
                                               : dot11_tx_pkg::FIELD_PSDU;
            end
            S_TAIL: begin
                emit          = out_free;
                nxt_bit.field = dot11_tx_pkg::FIELD_TAIL;
                nxt_bit.last  = tail_done && sym_wrap;
            end
            S_PAD: begin
                emit          = out_free;
                nxt_bit.field = dot11_tx_pkg::FIELD_PAD;
                nxt_bit.last  = sym_wrap;
            end
            default: begin
                emit = 1'b0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Field FSM and counters
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_int) begin
            state       <= S_IDLE;
            o_bit_valid <= 1'b0;
            sym_cnt     <= 8'd0;
            svc_cnt     <= 4'd0;
            bit_idx     <= 3'd0;
            tail_cnt    <= 3'd0;
        end else if (emit) begin
            o_bit_valid <= 1'b1;
            // Symbol counter ends at zero on the final bit of a frame
            sym_cnt     <= sym_wrap ? 8'd0 : sym_cnt + 8'd1;
            case (state)
                S_IDLE: begin
                    svc_cnt <= svc_cnt + 4'd1;
                    state   <= S_SERVICE;
                end
                S_SERVICE: begin
                    svc_cnt <= svc_cnt + 4'd1;
                    if (svc_cnt == 4'(dot11_tx_pkg::SERVICE_BITS - 1)) begin
                        state <= S_BYTE;
                    end
                end
                S_BYTE: begin
                    bit_idx <= bit_idx + 3'd1;
                    if (bit_idx == 3'd7 && i_byte.last) begin
                        state <= S_TAIL;
                    end
                end
                S_TAIL: begin
                    tail_cnt <= tail_done ? 3'd0 : tail_cnt + 3'd1;
                    if (tail_done) begin
                        state <= sym_wrap ? S_IDLE : S_PAD;
                    end
                end
                S_PAD: begin
                    if (sym_wrap) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end else if (i_bit_ready) begin
            o_bit_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (emit) begin
            o_bit <= nxt_bit;
        end
    end

    // Rate of the current frame, captured with the header
    always_ff @(posedge clk) begin
        if (reset_int) begin
            rate_q <= dot11_tx_pkg::RATE_6;
        end else if (emit && state == S_IDLE) begin
            rate_q <= i_hdr.rate;
        end
    end

endmodule

//--- design/conv_encoder.sv
`timescale 1ns/1ps

module conv_encoder (
    input  logic                      clk,
    input  logic                      reset_int,
    input  dot11_tx_pkg::tx_bit_t     i_bit,
    input  logic                      i_bit_valid,
    output logic                      o_bit_ready,
    output dot11_tx_pkg::coded_pair_t o_pair,
    output logic                      o_pair_valid,
    input  logic                      i_pair_ready
);

    // hist[5] is the previous bit, hist[0] the oldest
    logic [dot11_tx_pkg::CONV_K-2:0] hist;
    logic [dot11_tx_pkg::CONV_K-1:0] window;
    logic                            take;

    assign o_bit_ready = !o_pair_valid || i_pair_ready;
    assign take        = i_bit_valid && o_bit_ready;

    // Generator MSB taps the current input bit
    assign window = {i_bit.data_bit, i_bit.first ? '0 : hist};

    always_ff @(posedge clk) begin
        if (reset_int) begin
            o_pair_valid <= 1'b0;
            hist         <= '0;
        end else if (take) begin
            o_pair_valid <= 1'b1;
            hist         <= window[dot11_tx_pkg::CONV_K-1:1];
        end else if (i_pair_ready) begin
            o_pair_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            o_pair.pair[0] <= ^(window & dot11_tx_pkg::CONV_G0);
            o_pair.pair[1] <= ^(window & dot11_tx_pkg::CONV_G1);
            o_pair.last    <= i_bit.last;
        end
    end

endmodule

//--- design/data_scrambler.sv
`timescale 1ns/1ps

module data_scrambler (
    input  logic                  clk,
    input  logic                  reset_int,
    input  dot11_tx_pkg::tx_bit_t i_bit,
    input  logic                  i_bit_valid,
    output logic                  o_bit_ready,
    output dot11_tx_pkg::tx_bit_t o_bit,
    output logic                  o_bit_valid,
    input  logic                  i_bit_ready
);

    logic [6:0] scram_state;
    logic [6:0] base;
    logic       fb;
    logic       take;
    logic       is_tail;

    assign o_bit_ready = !o_bit_valid || i_bit_ready;
    assign take        = i_bit_valid && o_bit_ready;
    assign is_tail     = (i_bit.field == dot11_tx_pkg::FIELD_TAIL);

    // x^7 + x^4 + 1, restarted from the seed on the first bit
    assign base = i_bit.first ? i_bit.scram_seed : scram_state;
    assign fb   = base[6] ^ base[3];

    always_ff @(posedge clk) begin
        if (reset_int) begin
            o_bit_valid <= 1'b0;
            scram_state <= 7'd0;
        end else if (take) begin
            o_bit_valid <= 1'b1;
            // Tail bits leave the scrambler frozen
            scram_state <= is_tail ? base : {base[5:0], fb};
        end else if (i_bit_ready) begin
            o_bit_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            o_bit          <= i_bit;
            o_bit.data_bit <= is_tail ? 1'b0 : (i_bit.data_bit ^ fb);
        end
    end

endmodule

//--- design/dot11_tx_coder.sv
`timescale 1ns/1ps

module dot11_tx_coder (
    input  logic                      clk,
    input  logic                      reset_int,
    input  dot11_tx_pkg::frame_hdr_t  i_hdr,
    input  logic                      i_hdr_valid,
    output logic                      o_hdr_ready,
    input  dot11_tx_pkg::byte_beat_t  i_byte,
    input  logic                      i_byte_valid,
    output logic                      o_byte_ready,
    output dot11_tx_pkg::coded_pair_t o_pair,
    output logic                      o_pair_valid,
    input  logic                      i_pair_ready
);

    //////////////////////////////////////////////////////////////////////
    // Stage links
    //////////////////////////////////////////////////////////////////////
    dot11_tx_pkg::byte_beat_t fcs_byte;
    logic                     fcs_byte_valid;
    logic                     fcs_byte_ready;

    dot11_tx_pkg::tx_bit_t    raw_bit;
    logic                     raw_bit_valid;
    logic                     raw_bit_ready;

    dot11_tx_pkg::tx_bit_t    scr_bit;
    logic                     scr_bit_valid;
    logic                     scr_bit_ready;

    // PSDU bytes plus appended FCS
    fcs_inserter u_fcs_inserter (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_byte       (i_byte),
        .i_byte_valid (i_byte_valid),
        .o_byte_ready (o_byte_ready),
        .o_byte       (fcs_byte),
        .o_byte_valid (fcs_byte_valid),
        .i_byte_ready (fcs_byte_ready)
    );

    // DATA field bits, one per beat
    bit_serializer u_bit_serializer (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_hdr        (i_hdr),
        .i_hdr_valid  (i_hdr_valid),
        .o_hdr_ready  (o_hdr_ready),
        .i_byte       (fcs_byte),
        .i_byte_valid (fcs_byte_valid),
        .o_byte_ready (fcs_byte_ready),
        .o_bit        (raw_bit),
        .o_bit_valid  (raw_bit_valid),
        .i_bit_ready  (raw_bit_ready)
    );

    data_scrambler u_data_scrambler (
        .clk         (clk),
        .reset_int   (reset_int),
        .i_bit       (raw_bit),
        .i_bit_valid (raw_bit_valid),
        .o_bit_ready (raw_bit_ready),
        .o_bit       (scr_bit),
        .o_bit_valid (scr_bit_valid),
        .i_bit_ready (scr_bit_ready)
    );

    conv_encoder u_conv_encoder (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_bit        (scr_bit),
        .i_bit_valid  (scr_bit_valid),
        .o_bit_ready  (scr_bit_ready),
        .o_pair       (o_pair),
        .o_pair_valid (o_pair_valid),
        .i_pair_ready (i_pair_ready)
    );

endmodule

//--- design/dot11_tx_pkg.sv
package dot11_tx_pkg;

    //////////////////////////////////////////////////////////////////////
    // Coding constants
    //////////////////////////////////////////////////////////////////////
    localparam int SERVICE_BITS = 16;
    localparam int TAIL_BITS    = 6;

    // Reflected CRC-32, shifted out LSB first
    localparam logic [31:0] CRC_POLY = 32'hEDB88320;
    localparam logic [31:0] CRC_INIT = 32'hFFFFFFFF;

    // Industry standard K=7 code, generators in octal
    localparam int          CONV_K  = 7;
    localparam logic [6:0]  CONV_G0 = 7'o133;
    localparam logic [6:0]  CONV_G1 = 7'o171;

    //////////////////////////////////////////////////////////////////////
    // Enums
    //////////////////////////////////////////////////////////////////////
    // Legacy RATE codes as carried in the SIGNAL field
    typedef enum logic [3:0] {
        RATE_6  = 4'b1011,
        RATE_9  = 4'b1111,
        RATE_12 = 4'b1010,
        RATE_18 = 4'b1110,
        RATE_24 = 4'b1001,
        RATE_36 = 4'b1101,
        RATE_48 = 4'b1000,
        RATE_54 = 4'b1100
    } rate_e;

    typedef enum logic [2:0] {
        FIELD_SERVICE,
        FIELD_PSDU,
        FIELD_FCS,
        FIELD_TAIL,
        FIELD_PAD
    } field_e;

    //////////////////////////////////////////////////////////////////////
    // Stream beats
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        rate_e      rate;
        logic [6:0] scram_seed;
    } frame_hdr_t;

    typedef struct packed {
        logic [7:0] data;
        logic       first;
        logic       last;
    } byte_beat_t;

    // Seed is only meaningful on the first bit of a frame
    typedef struct packed {
        logic       data_bit;
        field_e     field;
        logic       first;
        logic       last;
        logic [6:0] scram_seed;
    } tx_bit_t;

    // pair[0] is the g0 output, pair[1] the g1 output
    typedef struct packed {
        logic [1:0] pair;
        logic       last;
    } coded_pair_t;

    // Data bits per OFDM symbol, unknown codes fall back to 6 Mbps
    function automatic logic [7:0] dbps_for_rate(input rate_e rate);
        logic [7:0] dbps;
        case (rate)
            RATE_6:  dbps = 8'd24;
            RATE_9:  dbps = 8'd36;
            RATE_12: dbps = 8'd48;
            RATE_18: dbps = 8'd72;
            RATE_24: dbps = 8'd96;
            RATE_36: dbps = 8'd144;
            RATE_48: dbps = 8'd192;
            RATE_54: dbps = 8'd216;
            default: dbps = 8'd24;
        endcase
        return dbps;
    endfunction

endpackage

//--- design/fcs_inserter.sv
`timescale 1ns/1ps

module fcs_inserter (
    input  logic                     clk,
    input  logic                     reset_int,
    input  dot11_tx_pkg::byte_beat_t i_byte,
    input  logic                     i_byte_valid,
    output logic                     o_byte_ready,
    output dot11_tx_pkg::byte_beat_t o_byte,
    output logic                     o_byte_valid,
    input  logic                     i_byte_ready
);

    // One byte of the reflected CRC-32, LSB first
    function automatic logic [31:0] crc32_byte(input logic [31:0] crc_in,
                                               input logic [7:0]  data);
        logic [31:0] c;
        c = crc_in;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ data[i]) begin
                c = (c >> 1) ^ dot11_tx_pkg::CRC_POLY;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

    logic [31:0] crc;
    logic [31:0] fcs;
    logic        fcs_active;
    logic [1:0]  fcs_idx;
    logic        out_free;
    logic        take;
    logic        send_fcs;

    assign out_free     = !o_byte_valid || i_byte_ready;
    assign o_byte_ready = out_free && !fcs_active;
    assign take         = i_byte_valid && o_byte_ready;
    assign send_fcs     = fcs_active && out_free;
    assign fcs          = ~crc;

    always_ff @(posedge clk) begin
        if (reset_int) begin
            o_byte_valid <= 1'b0;
            fcs_active   <= 1'b0;
            fcs_idx      <= 2'd0;
        end else begin
            if (take) begin
                o_byte_valid <= 1'b1;
                fcs_active   <= i_byte.last;
                fcs_idx      <= 2'd0;
            end else if (send_fcs) begin
                o_byte_valid <= 1'b1;
                fcs_idx      <= fcs_idx + 2'd1;
                fcs_active   <= (fcs_idx != 2'd3);
            end else if (i_byte_ready) begin
                o_byte_valid <= 1'b0;
            end
        end
    end

    // PSDU bytes pass through, then the FCS low byte first
    always_ff @(posedge clk) begin
        if (take) begin
            crc          <= crc32_byte(i_byte.first ? dot11_tx_pkg::CRC_INIT : crc, i_byte.data);
            o_byte.data  <= i_byte.data;
            o_byte.first <= i_byte.first;
            o_byte.last  <= 1'b0;
        end else if (send_fcs) begin
            o_byte.data  <= fcs[{fcs_idx, 3'b000} +: 8];
            o_byte.first <= 1'b0;
            o_byte.last  <= (fcs_idx == 2'd3);
        end
    end

endmodule

//--- dot11_tx_coder.f
design/dot11_tx_pkg.sv
design/fcs_inserter.sv
design/bit_serializer.sv
design/data_scrambler.sv
design/conv_encoder.sv
design/dot11_tx_coder.sv
dv/tb_dot11_tx_coder.sv

//--- dv/tb_dot11_tx_coder.sv
`timescale 1ns/1ps

module tb_dot11_tx_coder;

    localparam int TIMEOUT = 5000;

    logic                      clk;
    logic                      reset_int;
    dot11_tx_pkg::frame_hdr_t  i_hdr;
    logic                      i_hdr_valid;
    logic                      o_hdr_ready;
    dot11_tx_pkg::byte_beat_t  i_byte;
    logic                      i_byte_valid;
    logic                      o_byte_ready;
    dot11_tx_pkg::coded_pair_t o_pair;
    logic                      o_pair_valid;
    logic                      i_pair_ready;

    dot11_tx_pkg::coded_pair_t exp_q[$];
    int                        exp_len_q[$];
    int                        stall_pct;
    int                        gap_pct;
    int                        frame_pairs;
    int                        checks;
    int                        errors;
    int                        timeouts;

    // Rate codes and their data bits per OFDM symbol
    dot11_tx_pkg::rate_e rate_list[8] = '{dot11_tx_pkg::RATE_6, dot11_tx_pkg::RATE_9,
                                          dot11_tx_pkg::RATE_12, dot11_tx_pkg::RATE_18,
                                          dot11_tx_pkg::RATE_24, dot11_tx_pkg::RATE_36,
                                          dot11_tx_pkg::RATE_48, dot11_tx_pkg::RATE_54};
    int                  dbps_list[8] = '{24, 36, 48, 72, 96, 144, 192, 216};

    dot11_tx_coder UUT (
        .clk          (clk),
        .reset_int    (reset_int),
        .i_hdr        (i_hdr),
        .i_hdr_valid  (i_hdr_valid),
        .o_hdr_ready  (o_hdr_ready),
        .i_byte       (i_byte),
        .i_byte_valid (i_byte_valid),
        .o_byte_ready (o_byte_ready),
        .o_pair       (o_pair),
        .o_pair_valid (o_pair_valid),
        .i_pair_ready (i_pair_ready)
    );

    always #2 clk = ~clk;

    task automatic finish_run();
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic note_timeout(input string what);
        timeouts++;
        $display("Timeout at %0t while waiting for %s", $time, what);
        finish_run();
    endtask

    function automatic int gap_cycles();
        return (int'($urandom_range(99)) < gap_pct) ? int'($urandom_range(3, 1)) : 0;
    endfunction

    ////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////
    task automatic model_frame(input int dbps, input logic [6:0] seed,
                               input logic [7:0] psdu[$]);
        logic                      bits[$];
        logic                      tail[$];
        logic                      scr[$];
        logic [31:0]               crc;
        logic [6:0]                state;
        logic [6:0]                d;
        logic                      fb;
        dot11_tx_pkg::coded_pair_t cp;
        crc = 32'hFFFFFFFF;
        for (int i = 0; i < 16; i++) begin
            bits.push_back(1'b0);
            tail.push_back(1'b0);
        end
        foreach (psdu[b]) begin
            for (int j = 0; j < 8; j++) begin
                bits.push_back(psdu[b][j]);
                tail.push_back(1'b0);
                fb  = crc[0] ^ psdu[b][j];
                crc = crc >> 1;
                if (fb) begin
                    crc = crc ^ 32'hEDB88320;
                end
            end
        end
        // FCS goes out low byte first, so bit order is plain LSB first
        crc = ~crc;
        for (int j = 0; j < 32; j++) begin
            bits.push_back(crc[j]);
            tail.push_back(1'b0);
        end
        for (int i = 0; i < 6; i++) begin
            bits.push_back(1'b0);
            tail.push_back(1'b1);
        end
        while (bits.size() % dbps != 0) begin
            bits.push_back(1'b0);
            tail.push_back(1'b0);
        end
        state = seed;
        foreach (bits[i]) begin
            if (tail[i]) begin
                scr.push_back(1'b0);
            end else begin
                fb    = state[6] ^ state[3];
                scr.push_back(bits[i] ^ fb);
                state = {state[5:0], fb};
            end
        end
        // d[k] is the scrambled bit k steps back
        foreach (scr[i]) begin
            for (int k = 0; k < 7; k++) begin
                d[k] = (i >= k) ? scr[i - k] : 1'b0;
            end
            cp.pair[0] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6];
            cp.pair[1] = d[0] ^ d[1] ^ d[2] ^ d[3] ^ d[6];
            cp.last    = (i == scr.size() - 1);
            exp_q.push_back(cp);
        end
        exp_len_q.push_back(dbps * ((54 + 8 * psdu.size() + dbps - 1) / dbps));
    endtask

    ////////////////////////////////////////////////////////////////////
    // Stimulus tasks start and end on a falling edge
    ////////////////////////////////////////////////////////////////////
    task automatic await_handshake(input bit is_hdr, input string what);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        while (!taken) begin
            #1;
            taken = is_hdr ? o_hdr_ready : o_byte_ready;
            @(negedge clk);
            waited++;
            if (!taken && waited > TIMEOUT) begin
                note_timeout(what);
            end
        end
    endtask

    task automatic push_hdr(input dot11_tx_pkg::frame_hdr_t hdr);
        repeat (gap_cycles()) @(negedge clk);
        i_hdr       = hdr;
        i_hdr_valid = 1'b1;
        await_handshake(1'b1, "header acceptance");
        i_hdr_valid = 1'b0;
    endtask

    task automatic push_bytes(input logic [7:0] psdu[$]);
        dot11_tx_pkg::byte_beat_t beat;
        for (int i = 0; i < psdu.size(); i++) begin
            i_byte_valid = 1'b0;
            repeat (gap_cycles()) @(negedge clk);
            beat.data    = psdu[i];
            beat.first   = (i == 0);
            beat.last    = (i == psdu.size() - 1);
            i_byte       = beat;
            i_byte_valid = 1'b1;
            await_handshake(1'b0, "PSDU byte acceptance");
        end
        i_byte_valid = 1'b0;
    endtask

    task automatic send_frame(input int idx, input logic [6:0] seed,
                              input logic [7:0] psdu[$]);
        dot11_tx_pkg::frame_hdr_t hdr;
        hdr.rate       = rate_list[idx];
        hdr.scram_seed = seed;
        model_frame(dbps_list[idx], seed, psdu);
        fork
            push_hdr(hdr);
            push_bytes(psdu);
        join
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > TIMEOUT) begin
                note_timeout("output drain");
            end
        end
    endtask

    task automatic drive_ready();
        forever begin
            @(negedge clk);
            i_pair_ready = (int'($urandom_range(99)) >= stall_pct);
        end
    endtask

    ////////////////////////////////////////////////////////////////////
    // Output checker
    ////////////////////////////////////////////////////////////////////
    task automatic check_output();
        dot11_tx_pkg::coded_pair_t want;
        int                        want_len;
        forever begin
            @(negedge clk);
            #1;
            if (!reset_int && o_pair_valid && i_pair_ready) begin
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("Unexpected coded pair at %0t with no frame pending", $time);
                end
                if (exp_q.size() != 0) begin
                    want = exp_q.pop_front();
                    frame_pairs++;
                    checks++;
                    assert (o_pair.pair == want.pair) else begin
                        errors++;
                        $display("ERR %0t o_pair.pair exp %b got %b",
                                 $time, want.pair, o_pair.pair);
                    end
                    assert (o_pair.last == want.last) else begin
                        errors++;
                        $display("ERR %0t o_pair.last exp %b got %b",
                                 $time, want.last, o_pair.last);
                    end
                    if (o_pair.last && exp_len_q.size() != 0) begin
                        want_len = exp_len_q.pop_front();
                        assert (frame_pairs == want_len) else begin
                            errors++;
                            $display("ERR %0t pair count exp %0d got %0d",
                                     $time, want_len, frame_pairs);
                        end
                        frame_pairs = 0;
                    end
                end
            end
        end
    endtask

    initial begin
        logic [7:0] psdu[$];
        logic [6:0] seed;
        int         idx;
        void'($urandom(52));
        clk          = 1'b0;
        reset_int    = 1'b1;
        i_hdr        = '0;
        i_hdr_valid  = 1'b0;
        i_byte       = '0;
        i_byte_valid = 1'b0;
        i_pair_ready = 1'b0;
        stall_pct    = 0;
        gap_pct      = 0;
        frame_pairs  = 0;
        checks       = 0;
        errors       = 0;
        timeouts     = 0;
        fork
            drive_ready();
            check_output();
        join_none
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_int = 1'b0;

        // Idle outputs right after reset
        repeat (3) begin
            @(negedge clk);
            #1;
            checks++;
            assert (!o_pair_valid && !o_hdr_ready) else begin
                errors++;
                $display("ERR %0t o_pair_valid,o_hdr_ready exp 0,0 got %b,%b",
                         $time, o_pair_valid, o_hdr_ready);
            end
        end
        @(negedge clk);

        // Short 6 Mbps frame
        psdu = '{8'h04, 8'h02, 8'h00, 8'h2e};
        send_frame(0, 7'h5d, psdu);
        wait_drain();

        // Back-to-back random frames with stalls and gaps in the second half
        for (int n = 0; n < 48; n++) begin
            if (n == 24) begin
                stall_pct = 30;
                gap_pct   = 30;
            end
            idx  = (n % 24 < 8) ? n % 24 : int'($urandom_range(7));
            seed = 7'($urandom_range(127, 1));
            psdu.delete();
            repeat ($urandom_range(40, 1)) psdu.push_back(8'($urandom));
            send_frame(idx, seed, psdu);
        end
        wait_drain();
        repeat (20) @(negedge clk);
        finish_run();
    end

endmodule
